//--- yadan_macros.svh
`ifndef YADAN_MACROS_SVH
`define YADAN_MACROS_SVH

// datapath and register file
`define XLEN         32
`define REG_AW       5
`define NUM_REGS     32

// major opcodes
`define OPC_OP       7'b0110011
`define OPC_OP_IMM   7'b0010011
`define OPC_LUI      7'b0110111

// funct7 selects M extension or SUB/SRA
`define F7_MULDIV    7'b0000001
`define F7_ALT       7'b0100000

// base integer funct3
`define F3_ADD       3'b000
`define F3_SLL       3'b001
`define F3_SLT       3'b010
`define F3_SLTU      3'b011
`define F3_XOR       3'b100
`define F3_SR        3'b101
`define F3_OR        3'b110
`define F3_AND       3'b111

// unsigned M extension funct3
`define F3_MUL       3'b000
`define F3_MULHU     3'b011
`define F3_DIVU      3'b101
`define F3_REMU      3'b111

// one bit per iteration
`define MULDIV_STEPS 32

`endif

//--- hdl/yadan_pkg.sv
`default_nettype none

`include "yadan_macros.svh"

package yadan_pkg;

    // register-register layout
    typedef struct packed {
        logic [6:0]         funct7;
        logic [`REG_AW-1:0] rs2;
        logic [`REG_AW-1:0] rs1;
        logic [2:0]         funct3;
        logic [`REG_AW-1:0] rd;
        logic [6:0]         opcode;
    } r_type_t;

    // register-immediate layout
    typedef struct packed {
        logic [11:0]        imm12;
        logic [`REG_AW-1:0] rs1;
        logic [2:0]         funct3;
        logic [`REG_AW-1:0] rd;
        logic [6:0]         opcode;
    } i_type_t;

    // same instruction word, two views
    typedef union packed {
        r_type_t r;
        i_type_t i;
    } inst_u;

    typedef enum logic [4:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_MUL,
        ALU_MULHU,
        ALU_DIVU,
        ALU_REMU
    } alu_op_e;

    typedef struct packed {
        alu_op_e            alu_op;
        logic [`XLEN-1:0]   op_a;
        logic [`XLEN-1:0]   op_b;
        logic [`REG_AW-1:0] rd;
        logic               is_muldiv;
    } id_ex_t;

    // register write and retire record
    typedef struct packed {
        logic [`REG_AW-1:0] rd;
        logic [`XLEN-1:0]   result;
    } retire_t;

endpackage

`default_nettype wire

//--- hdl/pipe_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module pipe_ctrl (
    input  logic clk,
    input  logic rst_n_i,
    input  logic inst_valid_i,
    input  logic ex_is_muldiv_i,
    input  logic muldiv_done_i,
    output logic inst_ready_o,
    output logic ex_load_o,
    output logic ex_valid_o,
    output logic muldiv_start_o,
    output logic wb_load_o
);

    logic ex_valid_q;
    logic muldiv_busy_q;
    logic ex_holds_muldiv;

    assign ex_holds_muldiv = ex_valid_q & ex_is_muldiv_i;

    // stall while a muldiv sits in execute, done cycle included
    assign inst_ready_o   = ~ex_holds_muldiv;
    assign ex_load_o      = inst_valid_i & inst_ready_o;
    assign ex_valid_o     = ex_valid_q;

    // one pulse on the first muldiv cycle
    assign muldiv_start_o = ex_holds_muldiv & ~muldiv_busy_q;

    // ALU ops leave execute at once, muldiv ops wait for done
    assign wb_load_o      = ex_valid_q & (~ex_is_muldiv_i | muldiv_done_i);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ex_valid_q    <= 1'b0;
            muldiv_busy_q <= 1'b0;
        end else begin
            if (inst_ready_o) begin
                ex_valid_q <= inst_valid_i;
            end else if (muldiv_done_i) begin
                ex_valid_q <= 1'b0;
            end

            if (muldiv_start_o) begin
                muldiv_busy_q <= 1'b1;
            end else if (muldiv_done_i) begin
                muldiv_busy_q <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/inst_decode.sv
`timescale 1ns/1ns
`default_nettype none

`include "yadan_macros.svh"

module inst_decode import yadan_pkg::*; (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               ex_load_i,
    input  inst_u              inst_i,
    input  logic [`XLEN-1:0]   rs1_data_i,
    input  logic [`XLEN-1:0]   rs2_data_i,
    input  retire_t            ex_fwd_i,
    input  logic               ex_valid_i,
    input  retire_t            wb_fwd_i,
    input  logic               wb_valid_i,
    output logic [`REG_AW-1:0] rs1_addr_o,
    output logic [`REG_AW-1:0] rs2_addr_o,
    output id_ex_t             id_ex_o
);

    alu_op_e          op;
    logic             is_md;
    logic             legal;
    logic             use_imm;
    logic             is_lui;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] rs1_val;
    logic [`XLEN-1:0] rs2_val;
    id_ex_t           id_ex_d;

    // base integer op from funct3, alt picks SUB or SRA
    function automatic alu_op_e alu_f3_op(input logic [2:0] f3, input logic alt);
        alu_op_e sel;
        case (f3)
            `F3_ADD:  sel = alt ? ALU_SUB : ALU_ADD;
            `F3_SLL:  sel = ALU_SLL;
            `F3_SLT:  sel = ALU_SLT;
            `F3_SLTU: sel = ALU_SLTU;
            `F3_XOR:  sel = ALU_XOR;
            `F3_SR:   sel = alt ? ALU_SRA : ALU_SRL;
            `F3_OR:   sel = ALU_OR;
            default:  sel = ALU_AND;
        endcase
        return sel;
    endfunction

    // execute result wins over writeback, x0 never matches
    function automatic logic [`XLEN-1:0] fwd_sel(
        input logic [`REG_AW-1:0] addr,
        input logic [`XLEN-1:0]   rf_data,
        input logic               ex_vld,
        input retire_t            ex_rec,
        input logic               wb_vld,
        input retire_t            wb_rec
    );
        logic [`XLEN-1:0] val;
        val = rf_data;
        if (addr != '0) begin
            if (ex_vld && ex_rec.rd == addr) begin
                val = ex_rec.result;
            end else if (wb_vld && wb_rec.rd == addr) begin
                val = wb_rec.result;
            end
        end
        return val;
    endfunction

    assign rs1_addr_o = inst_i.r.rs1;
    assign rs2_addr_o = inst_i.r.rs2;

    assign rs1_val = fwd_sel(inst_i.r.rs1, rs1_data_i, ex_valid_i, ex_fwd_i, wb_valid_i, wb_fwd_i);
    assign rs2_val = fwd_sel(inst_i.r.rs2, rs2_data_i, ex_valid_i, ex_fwd_i, wb_valid_i, wb_fwd_i);

    always_comb begin
        op      = ALU_ADD;
        is_md   = 1'b0;
        legal   = 1'b1;
        use_imm = 1'b1;
        is_lui  = 1'b0;
        imm     = {{(`XLEN-12){inst_i.i.imm12[11]}}, inst_i.i.imm12};
        case (inst_i.r.opcode)
            `OPC_OP: begin
                use_imm = 1'b0;
                if (inst_i.r.funct7 == `F7_MULDIV) begin
                    is_md = 1'b1;
                    case (inst_i.r.funct3)
                        `F3_MUL:   op = ALU_MUL;
                        `F3_MULHU: op = ALU_MULHU;
                        `F3_DIVU:  op = ALU_DIVU;
                        `F3_REMU:  op = ALU_REMU;
                        default:   legal = 1'b0;
                    endcase
                end else begin
                    op = alu_f3_op(inst_i.r.funct3, inst_i.r.funct7 == `F7_ALT);
                end
            end
            `OPC_OP_IMM: begin
                // SRAI carries its alt bit where funct7 sits in R-type
                op = alu_f3_op(inst_i.i.funct3,
                               (inst_i.i.funct3 == `F3_SR) && (inst_i.r.funct7 == `F7_ALT));
            end
            `OPC_LUI: begin
                is_lui = 1'b1;
                imm    = {inst_i.i.imm12, inst_i.i.rs1, inst_i.i.funct3, 12'b0};
            end
            default: legal = 1'b0;
        endcase
    end

    // unsupported words retire as a harmless write of zero to x0
    always_comb begin
        id_ex_d.alu_op    = legal ? op : ALU_ADD;
        id_ex_d.op_a      = (is_lui || !legal) ? '0 : rs1_val;
        id_ex_d.op_b      = !legal ? '0 : (use_imm ? imm : rs2_val);
        id_ex_d.rd        = legal ? inst_i.r.rd : '0;
        id_ex_d.is_muldiv = legal && is_md;
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            id_ex_o <= '0;
        end else if (ex_load_i) begin
            id_ex_o <= id_ex_d;
        end
    end

endmodule

`default_nettype wire

//--- hdl/regs_file.sv
`timescale 1ns/1ns
`default_nettype none

`include "yadan_macros.svh"

module regs_file import yadan_pkg::*; (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               we_i,
    input  retire_t            wb_i,
    input  logic [`REG_AW-1:0] rs1_addr_i,
    input  logic [`REG_AW-1:0] rs2_addr_i,
    output logic [`XLEN-1:0]   rs1_data_o,
    output logic [`XLEN-1:0]   rs2_data_o
);

    // x0 has no storage
    logic [`XLEN-1:0] regs_q [1:`NUM_REGS-1];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 1; i < `NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && wb_i.rd != '0) begin
            regs_q[wb_i.rd] <= wb_i.result;
        end
    end

    // same-cycle writes reach decode through forwarding
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];

endmodule

`default_nettype wire

//--- hdl/alu_exec.sv
`timescale 1ns/1ns
`default_nettype none

`include "yadan_macros.svh"

module alu_exec import yadan_pkg::*; (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic             wb_load_i,
    input  id_ex_t           id_ex_i,
    input  logic [`XLEN-1:0] muldiv_result_i,
    output retire_t          ex_fwd_o,
    output logic             retire_valid_o,
    output retire_t          retire_o
);

    logic [4:0]       shamt;
    logic [`XLEN-1:0] alu_res;

    // shifts only look at the low five bits
    assign shamt = id_ex_i.op_b[4:0];

    always_comb begin
        case (id_ex_i.alu_op)
            ALU_ADD:  alu_res = id_ex_i.op_a + id_ex_i.op_b;
            ALU_SUB:  alu_res = id_ex_i.op_a - id_ex_i.op_b;
            ALU_SLL:  alu_res = id_ex_i.op_a << shamt;
            ALU_SLT: begin
                alu_res = {{(`XLEN-1){1'b0}},
                           $signed(id_ex_i.op_a) < $signed(id_ex_i.op_b)};
            end
            ALU_SLTU: begin
                alu_res = {{(`XLEN-1){1'b0}}, id_ex_i.op_a < id_ex_i.op_b};
            end
            ALU_XOR:  alu_res = id_ex_i.op_a ^ id_ex_i.op_b;
            ALU_SRL:  alu_res = id_ex_i.op_a >> shamt;
            ALU_SRA:  alu_res = $unsigned($signed(id_ex_i.op_a) >>> shamt);
            ALU_OR:   alu_res = id_ex_i.op_a | id_ex_i.op_b;
            ALU_AND:  alu_res = id_ex_i.op_a & id_ex_i.op_b;
            default:  alu_res = '0;
        endcase
    end

    // execute result, also the forwarding source for decode
    assign ex_fwd_o.rd     = id_ex_i.rd;
    assign ex_fwd_o.result = id_ex_i.is_muldiv ? muldiv_result_i : alu_res;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            retire_valid_o <= 1'b0;
        end else begin
            retire_valid_o <= wb_load_i;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_load_i) begin
            retire_o <= ex_fwd_o;
        end
    end

endmodule

`default_nettype wire

//--- hdl/mul_div_iter.sv
`timescale 1ns/1ns
`default_nettype none

`include "yadan_macros.svh"

module mul_div_iter import yadan_pkg::*; (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic             start_i,
    input  alu_op_e          op_i,
    input  logic [`XLEN-1:0] a_i,
    input  logic [`XLEN-1:0] b_i,
    output logic             done_o,
    output logic [`XLEN-1:0] result_o
);

    localparam int unsigned      CNT_W     = $clog2(`MULDIV_STEPS);
    localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(`MULDIV_STEPS - 1);

    // upper half accumulates product or remainder
    logic [2*`XLEN-1:0] work_q;
    logic [2*`XLEN-1:0] work_next;
    logic [`XLEN-1:0]   opnd_q;
    logic               is_div_q;
    logic               hi_sel_q;
    logic               running_q;
    logic               done_q;
    logic [CNT_W-1:0]   step_cnt_q;
    logic [`XLEN:0]     add_sum;
    logic [`XLEN:0]     rem_shift;
    logic [`XLEN:0]     rem_diff;

    always_comb begin
        add_sum   = {1'b0, work_q[2*`XLEN-1:`XLEN]} + {1'b0, opnd_q};
        rem_shift = work_q[2*`XLEN-1:`XLEN-1];
        rem_diff  = rem_shift - {1'b0, opnd_q};
        if (is_div_q) begin
            // restoring step, a zero divisor keeps subtracting nothing
            // so the quotient fills with ones and the dividend ends up on top
            if (rem_shift >= {1'b0, opnd_q}) begin
                work_next = {rem_diff[`XLEN-1:0], work_q[`XLEN-2:0], 1'b1};
            end else begin
                work_next = {rem_shift[`XLEN-1:0], work_q[`XLEN-2:0], 1'b0};
            end
        end else if (work_q[0]) begin
            work_next = {add_sum, work_q[`XLEN-1:1]};
        end else begin
            work_next = {1'b0, work_q[2*`XLEN-1:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            running_q  <= 1'b0;
            done_q     <= 1'b0;
            step_cnt_q <= '0;
        end else begin
            done_q <= running_q && (step_cnt_q == LAST_STEP);
            if (start_i) begin
                running_q  <= 1'b1;
                step_cnt_q <= '0;
            end else if (running_q) begin
                step_cnt_q <= step_cnt_q + 1'b1;
                if (step_cnt_q == LAST_STEP) begin
                    running_q <= 1'b0;
                end
            end
        end
    end

    // operands latched at start
    always_ff @(posedge clk) begin
        if (start_i) begin
            work_q   <= {{`XLEN{1'b0}}, a_i};
            opnd_q   <= b_i;
            is_div_q <= (op_i == ALU_DIVU) || (op_i == ALU_REMU);
            hi_sel_q <= (op_i == ALU_MULHU) || (op_i == ALU_REMU);
        end else if (running_q) begin
            work_q <= work_next;
        end
    end

    assign done_o   = done_q;
    assign result_o = hi_sel_q ? work_q[2*`XLEN-1:`XLEN] : work_q[`XLEN-1:0];

endmodule

`default_nettype wire

//--- hdl/yadan_core.sv
`timescale 1ns/1ns
`default_nettype none

`include "yadan_macros.svh"

module yadan_core import yadan_pkg::*; (
    input  logic    clk,
    input  logic    rst_n_i,

    // instruction port
    input  logic    inst_valid_i,
    input  inst_u   inst_i,
    output logic    inst_ready_o,

    // retire port
    output logic    retire_valid_o,
    output retire_t retire_o
);

    // decode <-> register file
    logic [`REG_AW-1:0] rs1_addr;
    logic [`REG_AW-1:0] rs2_addr;
    logic [`XLEN-1:0]   rs1_data;
    logic [`XLEN-1:0]   rs2_data;

    // decode/execute register and execute result
    id_ex_t             id_ex;
    retire_t            ex_fwd;

    // pipeline control
    logic               ex_load;
    logic               ex_valid;
    logic               wb_load;

    // muldiv handshake
    logic               muldiv_start;
    logic               muldiv_done;
    logic [`XLEN-1:0]   muldiv_result;

    pipe_ctrl u_pipe_ctrl (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .inst_valid_i    (inst_valid_i),
        .ex_is_muldiv_i  (id_ex.is_muldiv),
        .muldiv_done_i   (muldiv_done),
        .inst_ready_o    (inst_ready_o),
        .ex_load_o       (ex_load),
        .ex_valid_o      (ex_valid),
        .muldiv_start_o  (muldiv_start),
        .wb_load_o       (wb_load)
    );

    inst_decode u_inst_decode (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .ex_load_i       (ex_load),
        .inst_i          (inst_i),
        .rs1_data_i      (rs1_data),
        .rs2_data_i      (rs2_data),
        .ex_fwd_i        (ex_fwd),
        .ex_valid_i      (ex_valid),
        .wb_fwd_i        (retire_o),
        .wb_valid_i      (retire_valid_o),
        .rs1_addr_o      (rs1_addr),
        .rs2_addr_o      (rs2_addr),
        .id_ex_o         (id_ex)
    );

    // writeback port is the retire record
    regs_file u_regs_file (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .we_i            (retire_valid_o),
        .wb_i            (retire_o),
        .rs1_addr_i      (rs1_addr),
        .rs2_addr_i      (rs2_addr),
        .rs1_data_o      (rs1_data),
        .rs2_data_o      (rs2_data)
    );

    alu_exec u_alu_exec (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .wb_load_i       (wb_load),
        .id_ex_i         (id_ex),
        .muldiv_result_i (muldiv_result),
        .ex_fwd_o        (ex_fwd),
        .retire_valid_o  (retire_valid_o),
        .retire_o        (retire_o)
    );

    mul_div_iter u_mul_div_iter (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .start_i         (muldiv_start),
        .op_i            (id_ex.alu_op),
        .a_i             (id_ex.op_a),
        .b_i             (id_ex.op_b),
        .done_o          (muldiv_done),
        .result_o        (muldiv_result)
    );

endmodule

`default_nettype wire

//--- dv/yadan_core_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "yadan_macros.svh"

module yadan_core_tb import yadan_pkg::*; ();

    localparam int MAX_TESTS    = 64;
    localparam int CYCLES_PER_T = 40;

    logic    clk;
    logic    rst_n_i;
    logic    inst_valid_i;
    inst_u   inst_i;
    logic    inst_ready_o;
    logic    retire_valid_o;
    retire_t retire_o;

    logic [31:0] stim_word [0:MAX_TESTS-1];
    retire_t     stim_exp  [0:MAX_TESTS-1];
    int          num_tests;
    logic        stim_loaded;
    retire_t     exp_q [$];
    retire_t     exp_rec;
    integer      seed;
    int          gap;
    logic        prev_md;

    yadan_core uut (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .inst_valid_i   (inst_valid_i),
        .inst_i         (inst_i),
        .inst_ready_o   (inst_ready_o),
        .retire_valid_o (retire_valid_o),
        .retire_o       (retire_o)
    );

    always #4 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    // muldiv words hold execute for many cycles
    function automatic logic is_muldiv_word(input logic [31:0] word);
        inst_u w;
        w = word;
        return (w.r.opcode == `OPC_OP) && (w.r.funct7 == `F7_MULDIV);
    endfunction

    // one instruction per data line, other lines are skipped
    task automatic load_stim();
        int               fd;
        int               n;
        logic [8*96-1:0]  line;
        logic [31:0]      word_v;
        logic [31:0]      rd_v;
        logic [31:0]      res_v;
        fd = $fopen("dv/yadan_stim.txt", "r");
        if (fd == 0) begin
            fail_run("could not open the stimulus file dv/yadan_stim.txt");
        end else begin
            while ($fgets(line, fd) != 0 && num_tests < MAX_TESTS) begin
                n = $sscanf(line, "%h %h %h", word_v, rd_v, res_v);
                if (n == 3) begin
                    stim_word[num_tests]       = word_v;
                    stim_exp[num_tests].rd     = rd_v[4:0];
                    stim_exp[num_tests].result = res_v;
                    num_tests++;
                end
            end
            $fclose(fd);
        end
    endtask

    // retires are stable around the falling edge
    always @(negedge clk) begin
        if (rst_n_i && retire_valid_o) begin
            if (exp_q.size() == 0) begin
                fail_run("a retire appeared with no instruction outstanding");
            end else begin
                exp_rec = exp_q.pop_front();
                check_value("retire_o.rd", {27'b0, retire_o.rd}, {27'b0, exp_rec.rd});
                check_value("retire_o.result", retire_o.result, exp_rec.result);
            end
        end
    end

    // budget scales with the number of stim lines
    initial begin
        wait (stim_loaded);
        repeat (num_tests * CYCLES_PER_T + 8 + 20) @(posedge clk);
        fail_run("watchdog expired, retirement stalled");
    end

    initial begin
        clk          = 1'b0;
        rst_n_i      = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        seed         = 9;
        num_tests    = 0;
        stim_loaded  = 1'b0;
        prev_md      = 1'b0;

        load_stim();
        stim_loaded = 1'b1;

        repeat (8) @(posedge clk);
        rst_n_i <= 1'b1;

        @(negedge clk);
        check_value("inst_ready_o", {31'b0, inst_ready_o}, 32'd1);
        check_value("retire_valid_o", {31'b0, retire_valid_o}, 32'd0);
        @(posedge clk);

        for (int i = 0; i < num_tests; i++) begin
            gap = $unsigned($random(seed)) % 4;
            if (gap != 0) begin
                inst_valid_i <= 1'b0;
                repeat (gap) @(posedge clk);
            end
            inst_valid_i <= 1'b1;
            inst_i       <= stim_word[i];
            exp_q.push_back(stim_exp[i]);
            @(negedge clk);
            // a muldiv still stalls the port after the short idle gap
            check_value("inst_ready_o", {31'b0, inst_ready_o}, {31'b0, ~prev_md});
            // hold the word until ready is seen, then take the edge
            while (!inst_ready_o) begin
                @(negedge clk);
            end
            @(posedge clk);
            prev_md = is_muldiv_word(stim_word[i]);
        end
        inst_valid_i <= 1'b0;

        for (int k = 0; k < 100 && exp_q.size() != 0; k++) begin
            @(posedge clk);
        end
        // extra retires would show up here
        repeat (4) @(posedge clk);

        if (exp_q.size() == 0) begin
            $display("No errors");
            $finish;
        end else begin
            fail_run("some instructions never retired");
        end
    end

endmodule

`default_nettype wire

//--- dv/yadan_stim.txt
// one instruction per line in hex
// instruction word then expected rd then expected result
// register-immediate ops
00500093 01 00000005
ffd00113 02 fffffffd
00112193 03 00000001
00113213 04 00000000
0f00c293 05 000000f5
1000e313 06 00000105
7f017393 07 000007f0
00409413 08 00000050
01c15493 09 0000000f
40115513 0a fffffffe
123455b7 0b 12345000
// dependent register-register ops
00b08633 0c 12345005
401606b3 0d 12345000
00169733 0e 468a0000
00e127b3 0f 00000001
00f13833 10 00000000
002748b3 11 b975fffd
0088d933 12 0000b975
4088d9b3 13 ffffb975
01396a33 14 ffffb975
005a7ab3 15 00000075
// write to x0 then read it
00708013 00 0000000c
00100b33 16 00000005
// unsigned multiply and divide
02210bb3 17 00000009
02213c33 18 fffffffa
017c0cb3 19 00000003
0295dd33 1a 0136b000
0255fdb3 1b 0000000f
0200de33 1c ffffffff
0200feb3 1d 00000005
41ce8f33 1e 00000006
00006fb3 1f 00000000

//--- yadan_core.f
+incdir+.
hdl/yadan_pkg.sv
hdl/pipe_ctrl.sv
hdl/inst_decode.sv
hdl/regs_file.sv
hdl/alu_exec.sv
hdl/mul_div_iter.sv
hdl/yadan_core.sv
dv/yadan_core_tb.sv

//--- Bender.yml
package:
  name: yadan_core

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - hdl/yadan_pkg.sv
      - hdl/pipe_ctrl.sv
      - hdl/inst_decode.sv
      - hdl/regs_file.sv
      - hdl/alu_exec.sv
      - hdl/mul_div_iter.sv
      - hdl/yadan_core.sv
  - target: simulation
    files:
      - dv/yadan_core_tb.sv
